//--- gat_pkg.sv
package gat_pkg;

  // ==============================
  // Fixed data widths
  // ==============================
  parameter int DATA_WIDTH    = 8;
  parameter int WH_DATA_WIDTH = 12;
  parameter int ACC_WIDTH     = 24;

  // H values and weights
  typedef logic signed [DATA_WIDTH-1:0] data_t;

  // One output feature as stored in WH
  typedef logic signed [WH_DATA_WIDTH-1:0] wh_data_t;

  // Row accumulator, wide enough for a full row of 8x8 products
  typedef logic signed [ACC_WIDTH-1:0] acc_t;

  // ==============================
  // Decode FSM
  // ==============================
  typedef enum logic [2:0] {
    IDLE,
    INFO_RD,
    INFO_WAIT,
    H_RD,
    H_WAIT,
    ISSUE,
    DONE
  } decode_state_t;

endpackage

//--- gat_if.sv
`timescale 1ns/1ps

// H and node-info read path between decode and the memory controller
interface hbuf_rd_if #(
  parameter NUM_FEATURE_IN = 16,
  parameter TOTAL_NODES    = 8,
  parameter H_DEPTH        = 64,
  parameter MAX_NODES      = 8
);
  localparam H_ADDR_W    = $clog2(H_DEPTH);
  localparam INFO_ADDR_W = $clog2(TOTAL_NODES);
  localparam H_W         = $clog2(NUM_FEATURE_IN) + gat_pkg::DATA_WIDTH;
  localparam INFO_W      = 1 + $clog2(MAX_NODES) + $clog2(NUM_FEATURE_IN) + 1;

  logic [H_ADDR_W-1:0]    h_addr;
  logic [INFO_ADDR_W-1:0] info_addr;
  logic [H_W-1:0]         h_data;
  logic [INFO_W-1:0]      info_data;

  modport engine (output h_addr, output info_addr, input h_data, input info_data);
  modport mem (input h_addr, input info_addr, output h_data, output info_data);
endinterface

// Nonzero stream from decode to execute
interface nz_if #(
  parameter NUM_FEATURE_IN = 16,
  parameter TOTAL_NODES    = 8,
  parameter MAX_NODES      = 8
);
  logic                              valid;
  gat_pkg::data_t                    value;
  logic [$clog2(NUM_FEATURE_IN)-1:0] col_idx;
  logic [$clog2(TOTAL_NODES)-1:0]    row_idx;
  logic [$clog2(MAX_NODES)-1:0]      num_node;
  logic                              flag;
  logic                              last;
  logic                              empty;
  logic                              busy;

  modport src (
    output valid, value, col_idx, row_idx, num_node, flag, last, empty,
    input  busy
  );
  modport sink (
    input  valid, value, col_idx, row_idx, num_node, flag, last, empty,
    output busy
  );
endinterface

//--- bram.sv
`timescale 1ns/1ps

module bram #(
  parameter DATA_W = 8,
  parameter DEPTH  = 64,
  localparam ADDR_W = $clog2(DEPTH)
)(
  input  logic              clk,
  input  logic [DATA_W-1:0] din,
  input  logic [ADDR_W-1:0] addra,
  input  logic              ena,
  input  logic              wea,
  input  logic [ADDR_W-1:0] addrb,
  output logic [DATA_W-1:0] dout
);

  logic [DATA_W-1:0] mem [DEPTH];

  // Port a writes only
  always_ff @(posedge clk) begin
    if (ena && wea) begin
      mem[addra] <= din;
    end
  end

  // Port b registered read
  always_ff @(posedge clk) begin
    dout <= mem[addrb];
  end

endmodule

//--- dual_read_bram.sv
`timescale 1ns/1ps

module dual_read_bram #(
  parameter DATA_W = 8,
  parameter DEPTH  = 64,
  localparam ADDR_W = $clog2(DEPTH)
)(
  input  logic              clk,
  input  logic [DATA_W-1:0] din,
  input  logic [ADDR_W-1:0] addra,
  input  logic              ena,
  input  logic              wea,
  input  logic [ADDR_W-1:0] addrb,
  output logic [DATA_W-1:0] doutb,
  input  logic [ADDR_W-1:0] addrc,
  output logic [DATA_W-1:0] doutc
);

  logic [DATA_W-1:0] mem [DEPTH];

  always_ff @(posedge clk) begin
    if (ena && wea) begin
      mem[addra] <= din;
    end
  end

  // Two independent read ports, both one cycle of latency
  always_ff @(posedge clk) begin
    doutb <= mem[addrb];
    doutc <= mem[addrc];
  end

endmodule

//--- memory_controller.sv
`timescale 1ns/1ps

module memory_controller #(
  parameter NUM_FEATURE_IN  = 16,
  parameter NUM_FEATURE_OUT = 4,
  parameter TOTAL_NODES     = 8,
  parameter H_DEPTH         = 64,
  parameter MAX_NODES       = 8,

  localparam H_W         = $clog2(NUM_FEATURE_IN) + gat_pkg::DATA_WIDTH,
  localparam H_ADDR_W    = $clog2(H_DEPTH),
  localparam INFO_W      = 1 + $clog2(MAX_NODES) + $clog2(NUM_FEATURE_IN) + 1,
  localparam INFO_ADDR_W = $clog2(TOTAL_NODES),
  localparam WGT_DEPTH   = NUM_FEATURE_IN * NUM_FEATURE_OUT,
  localparam WGT_ADDR_W  = $clog2(WGT_DEPTH),
  localparam WH_W        = $clog2(MAX_NODES) + 1 + gat_pkg::WH_DATA_WIDTH * NUM_FEATURE_OUT,
  localparam WH_ADDR_W   = $clog2(TOTAL_NODES)
)(
  input  logic                          clk,
  input  logic                          reset,

  // PS load side
  input  logic                          h_we,
  input  logic [H_ADDR_W-1:0]           h_addr,
  input  logic [H_W-1:0]                h_din,
  input  logic                          info_we,
  input  logic [INFO_ADDR_W-1:0]        info_addr,
  input  logic [INFO_W-1:0]             info_din,
  input  logic                          wgt_we,
  input  logic [WGT_ADDR_W-1:0]         wgt_wr_addr,
  input  logic [gat_pkg::DATA_WIDTH-1:0] wgt_din,

  // PS readback
  input  logic [WGT_ADDR_W-1:0]         wgt_rd_addr,
  output logic [gat_pkg::DATA_WIDTH-1:0] wgt_rd_data,
  input  logic [WH_ADDR_W-1:0]          wh_rd_addr,
  output logic [WH_W-1:0]               wh_rd_data,

  // PL side
  hbuf_rd_if.mem                        hbuf,
  input  logic [WGT_ADDR_W-1:0]         wgt_addr,
  output logic [gat_pkg::DATA_WIDTH-1:0] wgt_data,
  input  logic                          wh_we,
  input  logic [WH_ADDR_W-1:0]          wh_addr,
  input  logic [WH_W-1:0]               wh_din
);

  logic h_wr_en;
  logic info_wr_en;
  logic wgt_wr_en;
  logic wh_wr_en;

  // No memory accepts a write while reset is held
  assign h_wr_en    = h_we & ~reset;
  assign info_wr_en = info_we & ~reset;
  assign wgt_wr_en  = wgt_we & ~reset;
  assign wh_wr_en   = wh_we & ~reset;

  // ==============================
  // Input memories, PS writes
  // ==============================
  bram #(.DATA_W(H_W), .DEPTH(H_DEPTH)) u_h_data_bram (
    .clk   (clk),
    .din   (h_din),
    .addra (h_addr),
    .ena   (h_wr_en),
    .wea   (h_wr_en),
    .addrb (hbuf.h_addr),
    .dout  (hbuf.h_data)
  );

  bram #(.DATA_W(INFO_W), .DEPTH(TOTAL_NODES)) u_node_info_bram (
    .clk   (clk),
    .din   (info_din),
    .addra (info_addr),
    .ena   (info_wr_en),
    .wea   (info_wr_en),
    .addrb (hbuf.info_addr),
    .dout  (hbuf.info_data)
  );

  // Port b for the execute stage, port c for PS readback
  dual_read_bram #(.DATA_W(gat_pkg::DATA_WIDTH), .DEPTH(WGT_DEPTH)) u_wgt_bram (
    .clk   (clk),
    .din   (wgt_din),
    .addra (wgt_wr_addr),
    .ena   (wgt_wr_en),
    .wea   (wgt_wr_en),
    .addrb (wgt_addr),
    .doutb (wgt_data),
    .addrc (wgt_rd_addr),
    .doutc (wgt_rd_data)
  );

  // ==============================
  // Result memory, PL writes
  // ==============================
  bram #(.DATA_W(WH_W), .DEPTH(TOTAL_NODES)) u_wh_bram (
    .clk   (clk),
    .din   (wh_din),
    .addra (wh_addr),
    .ena   (wh_wr_en),
    .wea   (wh_wr_en),
    .addrb (wh_rd_addr),
    .dout  (wh_rd_data)
  );

endmodule

//--- spmm_decode.sv
`timescale 1ns/1ps

module spmm_decode #(
  parameter NUM_FEATURE_IN = 16,
  parameter TOTAL_NODES    = 8,
  parameter H_DEPTH        = 64,
  parameter MAX_NODES      = 8,

  localparam COL_W      = $clog2(NUM_FEATURE_IN),
  localparam ROW_LEN_W  = $clog2(NUM_FEATURE_IN) + 1,
  localparam NUM_NODE_W = $clog2(MAX_NODES),
  localparam H_ADDR_W   = $clog2(H_DEPTH),
  localparam ROW_W      = $clog2(TOTAL_NODES)
)(
  input  logic      clk,
  input  logic      reset,
  input  logic      start,
  hbuf_rd_if.engine hbuf,
  nz_if.src         nz
);

  gat_pkg::decode_state_t state;

  logic [ROW_W-1:0]     row;
  logic [H_ADDR_W-1:0]  h_ptr;
  logic [ROW_LEN_W-1:0] row_len;
  logic [ROW_LEN_W-1:0] fetch_cnt;
  logic [ROW_LEN_W-1:0] info_row_len;

  // Node-info word is {flag, num_node, row_len}
  assign info_row_len   = hbuf.info_data[ROW_LEN_W-1:0];
  assign hbuf.info_addr = row;
  assign hbuf.h_addr    = h_ptr;

  // ==============================
  // Control
  // ==============================
  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= gat_pkg::IDLE;
      row       <= '0;
      h_ptr     <= '0;
      fetch_cnt <= '0;
      nz.valid  <= 1'b0;
    end else begin
      nz.valid <= 1'b0;
      case (state)
        gat_pkg::IDLE: begin
          if (start) begin
            row   <= '0;
            h_ptr <= '0;
            state <= gat_pkg::INFO_RD;
          end
        end
        gat_pkg::INFO_RD: state <= gat_pkg::INFO_WAIT;
        gat_pkg::INFO_WAIT: begin
          fetch_cnt <= '0;
          // Empty row goes out as a single item
          state <= (info_row_len == '0) ? gat_pkg::ISSUE : gat_pkg::H_RD;
        end
        gat_pkg::H_RD: state <= gat_pkg::H_WAIT;
        gat_pkg::H_WAIT: begin
          h_ptr     <= h_ptr + 1'b1;
          fetch_cnt <= fetch_cnt + 1'b1;
          state     <= gat_pkg::ISSUE;
        end
        gat_pkg::ISSUE: begin
          if (!nz.busy) begin
            nz.valid <= 1'b1;
            if (nz.last || nz.empty) begin
              if (row == ROW_W'(TOTAL_NODES - 1)) begin
                state <= gat_pkg::DONE;
              end else begin
                row   <= row + 1'b1;
                state <= gat_pkg::INFO_RD;
              end
            end else begin
              state <= gat_pkg::H_RD;
            end
          end
        end
        gat_pkg::DONE: state <= gat_pkg::IDLE;
        default: state <= gat_pkg::IDLE;
      endcase
    end
  end

  // Item fields, held stable through the valid cycle
  always_ff @(posedge clk) begin
    if (state == gat_pkg::INFO_WAIT) begin
      row_len     <= info_row_len;
      nz.row_idx  <= row;
      nz.num_node <= hbuf.info_data[ROW_LEN_W +: NUM_NODE_W];
      nz.flag     <= hbuf.info_data[ROW_LEN_W + NUM_NODE_W];
      nz.empty    <= (info_row_len == '0);
      nz.last     <= 1'b0;
    end
    if (state == gat_pkg::H_WAIT) begin
      nz.value   <= hbuf.h_data[gat_pkg::DATA_WIDTH-1:0];
      nz.col_idx <= hbuf.h_data[gat_pkg::DATA_WIDTH +: COL_W];
      nz.last    <= (fetch_cnt + 1'b1 == row_len);
    end
  end

endmodule

//--- spmm_execute.sv
`timescale 1ns/1ps

module spmm_execute #(
  parameter NUM_FEATURE_IN  = 16,
  parameter NUM_FEATURE_OUT = 4,
  parameter TOTAL_NODES     = 8,
  parameter MAX_NODES       = 8,

  localparam COL_W      = $clog2(NUM_FEATURE_IN),
  localparam WGT_ADDR_W = $clog2(NUM_FEATURE_IN * NUM_FEATURE_OUT),
  localparam ROW_W      = $clog2(TOTAL_NODES),
  localparam NUM_NODE_W = $clog2(MAX_NODES),
  localparam ACC_W      = gat_pkg::ACC_WIDTH
)(
  input  logic                             clk,
  input  logic                             reset,
  nz_if.sink                               nz,
  output logic [WGT_ADDR_W-1:0]            wgt_addr,
  input  gat_pkg::data_t                   wgt_data,
  output logic                             row_valid,
  output logic [ROW_W-1:0]                 row_idx,
  output logic [ACC_W*NUM_FEATURE_OUT-1:0] row_sum,
  output logic [NUM_NODE_W-1:0]            num_node,
  output logic                             flag
);

  localparam CNT_W = $clog2(NUM_FEATURE_OUT);
  localparam logic [CNT_W-1:0] LAST_J = CNT_W'(NUM_FEATURE_OUT - 1);

  gat_pkg::data_t   value_q;
  logic [COL_W-1:0] col_q;
  logic             last_q;
  logic             empty_q;
  logic             active;
  logic [CNT_W-1:0] rd_cnt;
  logic             rd_vld;
  logic [CNT_W-1:0] rd_j;
  gat_pkg::acc_t    acc [NUM_FEATURE_OUT];

  // Busy over the read cycles and the final add
  assign nz.busy  = active | rd_vld;
  assign wgt_addr = WGT_ADDR_W'(col_q * NUM_FEATURE_OUT + rd_cnt);

  always_ff @(posedge clk) begin
    if (reset) begin
      active    <= 1'b0;
      rd_cnt    <= '0;
      rd_vld    <= 1'b0;
      row_valid <= 1'b0;
    end else begin
      rd_vld    <= active;
      row_valid <= rd_vld && (rd_j == LAST_J) && (last_q || empty_q);
      if (nz.valid) begin
        active <= 1'b1;
        rd_cnt <= '0;
      end else if (active) begin
        rd_cnt <= rd_cnt + 1'b1;
        if (rd_cnt == LAST_J) begin
          active <= 1'b0;
        end
      end
    end
  end

  // Item and row metadata
  always_ff @(posedge clk) begin
    rd_j <= rd_cnt;
    if (nz.valid) begin
      value_q  <= nz.value;
      col_q    <= nz.col_idx;
      last_q   <= nz.last;
      empty_q  <= nz.empty;
      row_idx  <= nz.row_idx;
      num_node <= nz.num_node;
      flag     <= nz.flag;
    end
  end

  // One accumulator per output feature, cleared once the row is handed over
  always_ff @(posedge clk) begin
    for (int j = 0; j < NUM_FEATURE_OUT; j++) begin
      if (reset || row_valid) begin
        acc[j] <= '0;
      end else if (rd_vld && !empty_q && rd_j == CNT_W'(j)) begin
        acc[j] <= acc[j] + value_q * wgt_data;
      end
    end
  end

  for (genvar j = 0; j < NUM_FEATURE_OUT; j++) begin : g_pack
    assign row_sum[j*ACC_W +: ACC_W] = acc[j];
  end

endmodule

//--- wh_writeback.sv
`timescale 1ns/1ps

module wh_writeback #(
  parameter NUM_FEATURE_OUT = 4,
  parameter TOTAL_NODES     = 8,
  parameter MAX_NODES       = 8,

  localparam ROW_W      = $clog2(TOTAL_NODES),
  localparam NUM_NODE_W = $clog2(MAX_NODES),
  localparam ACC_W      = gat_pkg::ACC_WIDTH,
  localparam FEAT_W     = gat_pkg::WH_DATA_WIDTH,
  localparam WH_W       = NUM_NODE_W + 1 + FEAT_W * NUM_FEATURE_OUT
)(
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             row_valid,
  input  logic [ROW_W-1:0]                 row_idx,
  input  logic [ACC_W*NUM_FEATURE_OUT-1:0] row_sum,
  input  logic [NUM_NODE_W-1:0]            num_node,
  input  logic                             flag,
  output logic                             wh_we,
  output logic [ROW_W-1:0]                 wh_addr,
  output logic [WH_W-1:0]                  wh_din,
  output logic                             done
);

  localparam gat_pkg::acc_t SAT_MAX = (2 ** (FEAT_W - 1)) - 1;
  localparam gat_pkg::acc_t SAT_MIN = -(2 ** (FEAT_W - 1));

  logic [FEAT_W*NUM_FEATURE_OUT-1:0] feat_sat;

  // Clamp into the wh_data_t range
  function automatic gat_pkg::wh_data_t saturate(input gat_pkg::acc_t a);
    if (a > SAT_MAX) begin
      return gat_pkg::wh_data_t'(SAT_MAX);
    end else if (a < SAT_MIN) begin
      return gat_pkg::wh_data_t'(SAT_MIN);
    end
    return gat_pkg::wh_data_t'(a);
  endfunction

  for (genvar j = 0; j < NUM_FEATURE_OUT; j++) begin : g_sat
    assign feat_sat[j*FEAT_W +: FEAT_W] = saturate(row_sum[j*ACC_W +: ACC_W]);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wh_we <= 1'b0;
      done  <= 1'b0;
    end else begin
      wh_we <= row_valid;
      // Pulse once the final row has been written
      done  <= wh_we && (wh_addr == ROW_W'(TOTAL_NODES - 1));
    end
  end

  always_ff @(posedge clk) begin
    if (row_valid) begin
      wh_addr <= row_idx;
      wh_din  <= {num_node, flag, feat_sat};
    end
  end

endmodule

//--- gat_wh_top.sv
`timescale 1ns/1ps

module gat_wh_top #(
  parameter NUM_FEATURE_IN  = 16,
  parameter NUM_FEATURE_OUT = 4,
  parameter TOTAL_NODES     = 8,
  parameter H_DEPTH         = 64,
  parameter MAX_NODES       = 8,

  localparam H_W         = $clog2(NUM_FEATURE_IN) + gat_pkg::DATA_WIDTH,
  localparam H_ADDR_W    = $clog2(H_DEPTH),
  localparam INFO_W      = 1 + $clog2(MAX_NODES) + $clog2(NUM_FEATURE_IN) + 1,
  localparam INFO_ADDR_W = $clog2(TOTAL_NODES),
  localparam WGT_ADDR_W  = $clog2(NUM_FEATURE_IN * NUM_FEATURE_OUT),
  localparam WH_W        = $clog2(MAX_NODES) + 1 + gat_pkg::WH_DATA_WIDTH * NUM_FEATURE_OUT,
  localparam WH_ADDR_W   = $clog2(TOTAL_NODES)
)(
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           h_we,
  input  logic [H_ADDR_W-1:0]            h_addr,
  input  logic [H_W-1:0]                 h_din,
  input  logic                           info_we,
  input  logic [INFO_ADDR_W-1:0]         info_addr,
  input  logic [INFO_W-1:0]              info_din,
  input  logic                           wgt_we,
  input  logic [WGT_ADDR_W-1:0]          wgt_addr,
  input  logic [gat_pkg::DATA_WIDTH-1:0] wgt_din,
  input  logic                           start,
  input  logic [WGT_ADDR_W-1:0]          wgt_rd_addr,
  output logic [gat_pkg::DATA_WIDTH-1:0] wgt_rd_data,
  input  logic [WH_ADDR_W-1:0]           wh_rd_addr,
  output logic [WH_W-1:0]                wh_rd_data,
  output logic                           done
);

  localparam ACC_W = gat_pkg::ACC_WIDTH;

  logic [WGT_ADDR_W-1:0]            pl_wgt_addr;
  gat_pkg::data_t                   pl_wgt_data;
  logic                             row_valid;
  logic [INFO_ADDR_W-1:0]           row_idx;
  logic [ACC_W*NUM_FEATURE_OUT-1:0] row_sum;
  logic [$clog2(MAX_NODES)-1:0]     row_num_node;
  logic                             row_flag;
  logic                             wh_we;
  logic [WH_ADDR_W-1:0]             wh_addr;
  logic [WH_W-1:0]                  wh_din;

  hbuf_rd_if #(NUM_FEATURE_IN, TOTAL_NODES, H_DEPTH, MAX_NODES) hbuf ();
  nz_if #(NUM_FEATURE_IN, TOTAL_NODES, MAX_NODES) nz ();

  // ==============================
  // Memories
  // ==============================
  memory_controller #(
    .NUM_FEATURE_IN  (NUM_FEATURE_IN),
    .NUM_FEATURE_OUT (NUM_FEATURE_OUT),
    .TOTAL_NODES     (TOTAL_NODES),
    .H_DEPTH         (H_DEPTH),
    .MAX_NODES       (MAX_NODES)
  ) u_memory_controller (
    .clk         (clk),
    .reset       (reset),
    .h_we        (h_we),
    .h_addr      (h_addr),
    .h_din       (h_din),
    .info_we     (info_we),
    .info_addr   (info_addr),
    .info_din    (info_din),
    .wgt_we      (wgt_we),
    .wgt_wr_addr (wgt_addr),
    .wgt_din     (wgt_din),
    .wgt_rd_addr (wgt_rd_addr),
    .wgt_rd_data (wgt_rd_data),
    .wh_rd_addr  (wh_rd_addr),
    .wh_rd_data  (wh_rd_data),
    .hbuf        (hbuf),
    .wgt_addr    (pl_wgt_addr),
    .wgt_data    (pl_wgt_data),
    .wh_we       (wh_we),
    .wh_addr     (wh_addr),
    .wh_din      (wh_din)
  );

  // ==============================
  // Decode, execute, result
  // ==============================
  spmm_decode #(
    .NUM_FEATURE_IN (NUM_FEATURE_IN),
    .TOTAL_NODES    (TOTAL_NODES),
    .H_DEPTH        (H_DEPTH),
    .MAX_NODES      (MAX_NODES)
  ) u_spmm_decode (
    .clk   (clk),
    .reset (reset),
    .start (start),
    .hbuf  (hbuf),
    .nz    (nz)
  );

  spmm_execute #(
    .NUM_FEATURE_IN  (NUM_FEATURE_IN),
    .NUM_FEATURE_OUT (NUM_FEATURE_OUT),
    .TOTAL_NODES     (TOTAL_NODES),
    .MAX_NODES       (MAX_NODES)
  ) u_spmm_execute (
    .clk       (clk),
    .reset     (reset),
    .nz        (nz),
    .wgt_addr  (pl_wgt_addr),
    .wgt_data  (pl_wgt_data),
    .row_valid (row_valid),
    .row_idx   (row_idx),
    .row_sum   (row_sum),
    .num_node  (row_num_node),
    .flag      (row_flag)
  );

  wh_writeback #(
    .NUM_FEATURE_OUT (NUM_FEATURE_OUT),
    .TOTAL_NODES     (TOTAL_NODES),
    .MAX_NODES       (MAX_NODES)
  ) u_wh_writeback (
    .clk       (clk),
    .reset     (reset),
    .row_valid (row_valid),
    .row_idx   (row_idx),
    .row_sum   (row_sum),
    .num_node  (row_num_node),
    .flag      (row_flag),
    .wh_we     (wh_we),
    .wh_addr   (wh_addr),
    .wh_din    (wh_din),
    .done      (done)
  );

endmodule

//--- gat_tb.sv
`timescale 1ns/1ps

module gat_tb;

  localparam int NIN         = 16;
  localparam int NOUT        = 4;
  localparam int NODES       = 8;
  localparam int HDEPTH      = 64;
  localparam int MAXN        = 8;
  localparam int COL_W       = $clog2(NIN);
  localparam int LEN_W       = $clog2(NIN) + 1;
  localparam int NN_W        = $clog2(MAXN);
  localparam int H_W         = COL_W + gat_pkg::DATA_WIDTH;
  localparam int H_ADDR_W    = $clog2(HDEPTH);
  localparam int INFO_W      = 1 + NN_W + LEN_W;
  localparam int ROW_W       = $clog2(NODES);
  localparam int WGT_N       = NIN * NOUT;
  localparam int WGT_ADDR_W  = $clog2(WGT_N);
  localparam int FEAT_W      = gat_pkg::WH_DATA_WIDTH;
  localparam int WH_W        = NN_W + 1 + FEAT_W * NOUT;
  localparam int SAT_HI      = (1 << (FEAT_W - 1)) - 1;
  localparam int SAT_LO      = -(1 << (FEAT_W - 1));
  localparam int MAX_ROW_LEN = 8;
  localparam int RUN_TIMEOUT = 5000;

  logic                           clk;
  logic                           reset;
  logic                           h_we;
  logic [H_ADDR_W-1:0]            h_addr;
  logic [H_W-1:0]                 h_din;
  logic                           info_we;
  logic [ROW_W-1:0]               info_addr;
  logic [INFO_W-1:0]              info_din;
  logic                           wgt_we;
  logic [WGT_ADDR_W-1:0]          wgt_addr;
  logic [gat_pkg::DATA_WIDTH-1:0] wgt_din;
  logic                           start;
  logic [WGT_ADDR_W-1:0]          wgt_rd_addr;
  logic [gat_pkg::DATA_WIDTH-1:0] wgt_rd_data;
  logic [ROW_W-1:0]               wh_rd_addr;
  logic [WH_W-1:0]                wh_rd_data;
  logic                           done;

  // Testbench copies of the three input memories
  gat_pkg::data_t   h_val [HDEPTH];
  logic [COL_W-1:0] h_col [HDEPTH];
  int               row_len [NODES];
  logic [NN_W-1:0]  node_num [NODES];
  logic             node_flag [NODES];
  gat_pkg::data_t   wgt [WGT_N];

  logic [31:0] rng;
  int          errors;
  int          checks;
  int          done_count;
  logic        run_active;
  logic        ok;

  gat_wh_top #(
    .NUM_FEATURE_IN  (NIN),
    .NUM_FEATURE_OUT (NOUT),
    .TOTAL_NODES     (NODES),
    .H_DEPTH         (HDEPTH),
    .MAX_NODES       (MAXN)
  ) UUT (
    .clk         (clk),
    .reset       (reset),
    .h_we        (h_we),
    .h_addr      (h_addr),
    .h_din       (h_din),
    .info_we     (info_we),
    .info_addr   (info_addr),
    .info_din    (info_din),
    .wgt_we      (wgt_we),
    .wgt_addr    (wgt_addr),
    .wgt_din     (wgt_din),
    .start       (start),
    .wgt_rd_addr (wgt_rd_addr),
    .wgt_rd_data (wgt_rd_data),
    .wh_rd_addr  (wh_rd_addr),
    .wh_rd_data  (wh_rd_data),
    .done        (done)
  );

  always #10 clk = ~clk;

  // ==============================
  // Helpers
  // ==============================
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] rand_next();
    rng = xorshift32(rng);
    return rng;
  endfunction

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // Expected WH word: CSR walk over H, dot product with W, clamp to 12 bits
  function automatic logic [WH_W-1:0] wh_model(input int row);
    int              ptr;
    int              sum;
    int              col;
    logic [WH_W-1:0] word;
    ptr  = 0;
    word = '0;
    for (int r = 0; r < row; r++) begin
      ptr += row_len[r];
    end
    for (int j = 0; j < NOUT; j++) begin
      sum = 0;
      for (int k = 0; k < row_len[row]; k++) begin
        col = int'(h_col[ptr + k]);
        sum += int'(h_val[ptr + k]) * int'(wgt[col * NOUT + j]);
      end
      if (sum > SAT_HI) begin
        sum = SAT_HI;
      end else if (sum < SAT_LO) begin
        sum = SAT_LO;
      end
      word[j*FEAT_W +: FEAT_W] = sum[FEAT_W-1:0];
    end
    word[FEAT_W*NOUT]           = node_flag[row];
    word[WH_W-1 -: NN_W]        = node_num[row];
    return word;
  endfunction

  // ==============================
  // Stimulus data
  // ==============================
  task automatic make_graph();
    int          ptr;
    logic [31:0] r;
    ptr = 0;
    for (int a = 0; a < HDEPTH; a++) begin
      r = rand_next();
      h_val[a] = r[7:0];
      h_col[a] = r[8 +: COL_W];
    end
    for (int n = 0; n < NODES; n++) begin
      r = rand_next();
      row_len[n]   = int'(r[3:0]) % (MAX_ROW_LEN + 1);
      node_num[n]  = r[8 +: NN_W];
      node_flag[n] = r[16];
    end
    // Empty rows in the middle of the graph
    row_len[2] = 0;
    row_len[5] = 0;
    // Last two rows hit columns 0 and 1 only, to saturate
    row_len[6] = MAX_ROW_LEN;
    row_len[7] = MAX_ROW_LEN;
    for (int n = 0; n < 6; n++) begin
      ptr += row_len[n];
    end
    for (int k = 0; k < MAX_ROW_LEN; k++) begin
      h_val[ptr + k]               = 8'sh80;
      h_col[ptr + k]               = '0;
      h_val[ptr + MAX_ROW_LEN + k] = 8'sh80;
      h_col[ptr + MAX_ROW_LEN + k] = COL_W'(1);
    end
  endtask

  task automatic make_weights(input logic extreme);
    logic [31:0] r;
    for (int a = 0; a < WGT_N; a++) begin
      r = rand_next();
      wgt[a] = r[15:8];
    end
    if (extreme) begin
      // -128 * -128 on column 0, -128 * 127 on column 1
      for (int j = 0; j < NOUT; j++) begin
        wgt[j]        = 8'sh80;
        wgt[NOUT + j] = 8'sh7f;
      end
    end
  endtask

  // ==============================
  // PS side transfers
  // ==============================
  task automatic load_h();
    for (int a = 0; a < HDEPTH; a++) begin
      @(posedge clk);
      #2;
      h_we   = 1'b1;
      h_addr = H_ADDR_W'(a);
      h_din  = {h_col[a], h_val[a]};
    end
    @(posedge clk);
    #2;
    h_we = 1'b0;
  endtask

  task automatic load_info();
    for (int n = 0; n < NODES; n++) begin
      @(posedge clk);
      #2;
      info_we   = 1'b1;
      info_addr = ROW_W'(n);
      info_din  = {node_flag[n], node_num[n], LEN_W'(row_len[n])};
    end
    @(posedge clk);
    #2;
    info_we = 1'b0;
  endtask

  task automatic load_weights();
    for (int a = 0; a < WGT_N; a++) begin
      @(posedge clk);
      #2;
      wgt_we   = 1'b1;
      wgt_addr = WGT_ADDR_W'(a);
      wgt_din  = wgt[a];
    end
    @(posedge clk);
    #2;
    wgt_we = 1'b0;
  endtask

  task automatic check_weights();
    for (int a = 0; a < WGT_N; a++) begin
      @(posedge clk);
      #2;
      wgt_rd_addr = WGT_ADDR_W'(a);
      @(posedge clk);
      @(negedge clk);
      check($sformatf("wgt_rd_data[%0d]", a), wgt_rd_data, $unsigned(wgt[a]));
    end
  endtask

  task automatic read_wh();
    logic [WH_W-1:0] exp;
    for (int r = 0; r < NODES; r++) begin
      @(posedge clk);
      #2;
      wh_rd_addr = ROW_W'(r);
      @(posedge clk);
      @(negedge clk);
      exp = wh_model(r);
      check($sformatf("wh_rd_data[%0d]", r), wh_rd_data, exp);
    end
  endtask

  // Start pulse, then wait for done with a timeout
  task automatic run_engine(input int run_id, output logic finished);
    int   n;
    logic seen;
    n          = 0;
    seen       = 1'b0;
    done_count = 0;
    run_active = 1'b1;
    @(posedge clk);
    #2;
    start = 1'b1;
    @(posedge clk);
    #2;
    start = 1'b0;
    while (!seen && n < RUN_TIMEOUT) begin
      @(negedge clk);
      seen = done;
      n++;
    end
    if (!seen) begin
      errors++;
      $display("run %0d timed out after %0d cycles with no done pulse", run_id, n);
    end else begin
      // Window to catch a second done pulse
      repeat (20) @(negedge clk);
      check($sformatf("done pulses in run %0d", run_id), done_count, 1);
    end
    @(posedge clk);
    #2;
    run_active = 1'b0;
    finished   = seen;
  endtask

  // done must stay low outside a run
  always @(negedge clk) begin
    if (!reset) begin
      if (run_active) begin
        if (done) begin
          done_count++;
        end
      end else begin
        check("done", done, 1'b0);
      end
    end
  end

  // ==============================
  // Sequence
  // ==============================
  initial begin
    rng         = 32'h8157_85e5;
    errors      = 0;
    checks      = 0;
    done_count  = 0;
    run_active  = 1'b0;
    ok          = 1'b0;
    clk         = 1'b0;
    reset       = 1'b1;
    h_we        = 1'b0;
    h_addr      = '0;
    h_din       = '0;
    info_we     = 1'b0;
    info_addr   = '0;
    info_din    = '0;
    wgt_we      = 1'b0;
    wgt_addr    = '0;
    wgt_din     = '0;
    start       = 1'b0;
    wgt_rd_addr = '0;
    wh_rd_addr  = '0;

    repeat (16) @(posedge clk);
    #2;
    reset = 1'b0;
    repeat (10) @(posedge clk);

    // First run with saturating weights on columns 0 and 1
    make_graph();
    make_weights(1'b1);
    load_h();
    load_info();
    load_weights();
    check_weights();
    run_engine(1, ok);
    if (ok) begin
      read_wh();
    end

    // Second run, new weights over the same graph
    if (ok) begin
      make_weights(1'b0);
      load_weights();
      check_weights();
      run_engine(2, ok);
      if (ok) begin
        read_wh();
      end
    end

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- sim.f
gat_pkg.sv
gat_if.sv
bram.sv
dual_read_bram.sv
memory_controller.sv
spmm_decode.sv
spmm_execute.sv
wh_writeback.sv
gat_wh_top.sv
gat_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= gat_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build $(TOP) with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "^Result: PASSED$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
